// ==== filelist.f ====
+incdir+tests
src/simmem_pkg.sv
src/simmem_free_slots.sv
src/simmem_list_ctrl.sv
src/simmem_release_stage.sv
src/simmem_bank.sv
tests/tb_simmem_bank.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the response bank testbench with Verilator and run it.
# Exits non-zero when the log holds the fail message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f --top-module tb_simmem_bank -Mdir build

./build/Vtb_simmem_bank | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
echo "Run finished without failures"

// ==== src/simmem_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// Write response bank. Stores responses in a shared slot pool, keeps
// order per identifier and releases the lowest identifier first.
////////////////////////////////////////////////////////////////////////////

module simmem_bank import simmem_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  // Responses from the memory side
  input  logic i_in_valid,
  input  rsp_t i_in_rsp,
  output logic o_in_ready,

  // Responses towards the requester
  output logic o_out_valid,
  output rsp_t o_out_rsp,
  input  logic i_out_ready
);

  // Allocation
  logic  accept;
  slot_t alloc_slot;

  // Pop path between release stage and lists
  logic              pop;
  id_t               pop_id;
  pop_t              pop_head;
  logic [NumIds-1:0] nonempty;

  // Slot return on output handshake
  logic  release_slot_en;
  slot_t release_slot;

  simmem_free_slots free_slots_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_in_valid     (i_in_valid),
    .o_in_ready     (o_in_ready),
    .i_release      (release_slot_en),
    .i_release_slot (release_slot),
    .o_accept       (accept),
    .o_alloc_slot   (alloc_slot)
  );

  simmem_list_ctrl list_ctrl_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_push      (accept),
    .i_push_slot (alloc_slot),
    .i_push_rsp  (i_in_rsp),
    .i_pop       (pop),
    .i_pop_id    (pop_id),
    .o_nonempty  (nonempty),
    .o_pop_head  (pop_head)
  );

  simmem_release_stage release_stage_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_nonempty     (nonempty),
    .i_pop_head     (pop_head),
    .o_pop          (pop),
    .o_pop_id       (pop_id),
    .o_release      (release_slot_en),
    .o_release_slot (release_slot),
    .i_out_ready    (i_out_ready),
    .o_out_valid    (o_out_valid),
    .o_out_rsp      (o_out_rsp)
  );

endmodule

// ==== src/simmem_free_slots.sv ====
////////////////////////////////////////////////////////////////////////////
// Slot occupancy for the response bank. Allocates the lowest free slot
// to an accepted input and frees a slot when its response leaves.
////////////////////////////////////////////////////////////////////////////

module simmem_free_slots import simmem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Input handshake
  input  logic  i_in_valid,
  output logic  o_in_ready,

  // Slot returned by the output handshake
  input  logic  i_release,
  input  slot_t i_release_slot,

  // Accept strobe and allocated slot towards the list controller
  output logic  o_accept,
  output slot_t o_alloc_slot
);

  // One bit per slot, set while the slot holds a response
  logic [BankCapacity-1:0] occ_d, occ_q;
  logic [BankCapacity-1:0] free_slots;

  assign free_slots = ~occ_q;

  // Lowest free slot wins
  // Scan downwards so the last hit is the lowest index
  always_comb begin
    o_alloc_slot = '0;
    for (int i = BankCapacity - 1; i >= 0; i--) begin
      if (free_slots[i]) begin
        o_alloc_slot = slot_t'(i);
      end
    end
  end

  // Ready only from registered state, never from valid
  assign o_in_ready = |free_slots;
  assign o_accept = i_in_valid && o_in_ready;

  // Accept and release never hit the same slot
  // The allocated slot is free, the released one is occupied
  always_comb begin
    occ_d = occ_q;
    if (o_accept) begin
      occ_d[o_alloc_slot] = 1'b1;
    end
    if (i_release) begin
      occ_d[i_release_slot] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// ==== src/simmem_list_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-identifier linked lists over the shared slot pool. Holds the
// payload and next-pointer tables and answers pops combinationally.
////////////////////////////////////////////////////////////////////////////

module simmem_list_ctrl import simmem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Append an accepted response to the list of its identifier
  input  logic              i_push,
  input  slot_t             i_push_slot,
  input  rsp_t              i_push_rsp,

  // Remove the head of one list
  input  logic              i_pop,
  input  id_t               i_pop_id,

  output logic [NumIds-1:0] o_nonempty,
  output pop_t              o_pop_head
);

  // List length must reach BankCapacity, one bit wider than a slot index
  typedef logic [SlotWidth:0] len_t;

  ////////////////////////////////////////////////////////////////////////////
  // List state
  ////////////////////////////////////////////////////////////////////////////

  // Oldest and newest slot of each list
  slot_t head_d [NumIds];
  slot_t head_q [NumIds];
  slot_t tail_d [NumIds];
  slot_t tail_q [NumIds];
  len_t  len_d  [NumIds];
  len_t  len_q  [NumIds];

  // Storage indexed by slot
  rsp_t  rsp_q  [BankCapacity];
  slot_t next_q [BankCapacity];

  // Which list is pushed and which is popped this cycle
  logic [NumIds-1:0] push_sel;
  logic [NumIds-1:0] pop_sel;

  // Link the old tail to the new slot
  logic  link_en;
  slot_t link_slot;

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      push_sel[i] = i_push && (i_push_rsp.id == id_t'(i));
      pop_sel[i] = i_pop && (i_pop_id == id_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next-state of heads, tails and lengths
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    head_d = head_q;
    tail_d = tail_q;
    len_d = len_q;
    link_en = 1'b0;
    link_slot = '0;

    for (int i = 0; i < NumIds; i++) begin
      // Head walks through the next-pointer table
      if (pop_sel[i]) begin
        head_d[i] = next_q[head_q[i]];
      end

      if (push_sel[i]) begin
        tail_d[i] = i_push_slot;
        // Entries staying past this cycle keep the head, so chain after the tail
        if (len_q[i] > len_t'(pop_sel[i])) begin
          link_en = 1'b1;
          link_slot = tail_q[i];
        end else begin
          // List empty after this cycle, new slot is the head too
          head_d[i] = i_push_slot;
        end
      end

      // Simultaneous push and pop leaves the length unchanged
      len_d[i] = len_q[i] + len_t'(push_sel[i]) - len_t'(pop_sel[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '{default: '0};
      tail_q <= '{default: '0};
      len_q <= '{default: '0};
    end else begin
      head_q <= head_d;
      tail_q <= tail_d;
      len_q <= len_d;
    end
  end

  // Payload and link tables, only meaningful for occupied slots
  always_ff @(posedge clk_i) begin
    if (i_push) begin
      rsp_q[i_push_slot] <= i_push_rsp;
    end
    if (link_en) begin
      next_q[link_slot] <= i_push_slot;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      o_nonempty[i] = (len_q[i] != '0);
    end
  end

  // Head of the requested list, valid whenever that list is non-empty
  assign o_pop_head.rsp = rsp_q[head_q[i_pop_id]];
  assign o_pop_head.slot = head_q[i_pop_id];

endmodule

// ==== src/simmem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Sizing constants and packed types shared by the write response bank.
// Every bank module takes them by a wildcard import in its header.
////////////////////////////////////////////////////////////////////////////

package simmem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////////////////////////////////////////

  // Transaction identifiers, one linked list each
  localparam int unsigned NumIds = 4;
  localparam int unsigned IdWidth = 2;

  // Shared slot pool
  localparam int unsigned BankCapacity = 8;
  localparam int unsigned SlotWidth = 3;

  // Response content apart from the identifier
  localparam int unsigned PayloadWidth = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [SlotWidth-1:0] slot_t;

  // Write response as seen on both ports
  typedef struct packed {
    id_t id;
    logic [PayloadWidth-1:0] payload;
  } rsp_t;

  // Head of a list together with the slot it occupies
  typedef struct packed {
    rsp_t rsp;
    slot_t slot;
  } pop_t;

endpackage

// ==== src/simmem_release_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Output register of the response bank. Pops the lowest non-empty list
// into the register and returns the slot on each output handshake.
////////////////////////////////////////////////////////////////////////////

module simmem_release_stage import simmem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // From the list controller
  input  logic [NumIds-1:0] i_nonempty,
  input  pop_t              i_pop_head,

  // Pop request towards the list controller
  output logic              o_pop,
  output id_t               o_pop_id,

  // Slot freed by the output handshake
  output logic              o_release,
  output slot_t             o_release_slot,

  // Output handshake
  input  logic              i_out_ready,
  output logic              o_out_valid,
  output rsp_t              o_out_rsp
);

  logic out_valid_q;
  pop_t hold_q;
  logic can_load;
  logic handshake;

  // Lowest-numbered identifier with an entry
  always_comb begin
    o_pop_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (i_nonempty[i]) begin
        o_pop_id = id_t'(i);
      end
    end
  end

  assign handshake = out_valid_q && i_out_ready;

  // Register empty or being emptied this cycle
  assign can_load = !out_valid_q || i_out_ready;
  assign o_pop = can_load && (|i_nonempty);

  // Valid follows whether a new entry was available at the load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (can_load) begin
      out_valid_q <= |i_nonempty;
    end
  end

  // Held entry keeps its slot until the handshake
  always_ff @(posedge clk_i) begin
    if (o_pop) begin
      hold_q <= i_pop_head;
    end
  end

  assign o_release = handshake;
  assign o_release_slot = hold_q.slot;
  assign o_out_valid = out_valid_q;
  assign o_out_rsp = hold_q.rsp;

endmodule

// ==== tests/tb_simmem_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reference model of the response bank for its testbench. Holds the
// expected queues per identifier, the occupancy count, the compare tasks
// and the error counters. Included inside the testbench module.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_SIMMEM_MODEL_SVH
`define TB_SIMMEM_MODEL_SVH

// Expected responses per identifier, oldest first
rsp_t model_q [NumIds][$];

// Accepted inputs minus output handshakes
int occupancy;

int mismatch_count;
int failure_count;

task automatic compare_rsp(input string name, input rsp_t got, input rsp_t exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("MISMATCH time=%0t %s got id=%0d payload=%h expected id=%0d payload=%h",
             $time, name, got.id, got.payload, exp.id, exp.payload);
  end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("MISMATCH time=%0t %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic report_failure(input string msg);
  failure_count++;
  $display("ERROR time=%0t %s", $time, msg);
endtask

// Lowest identifier with pending entries
// Returns -1 when every queue is empty
function automatic int lowest_pending_id();
  int found;
  found = -1;
  for (int i = 0; i < NumIds; i++) begin
    if (found < 0 && model_q[i].size() != 0) begin
      found = i;
    end
  end
  return found;
endfunction

task automatic model_push(input rsp_t rsp);
  model_q[rsp.id].push_back(rsp);
  occupancy++;
endtask

// Priority mode expects the lowest pending identifier
// Otherwise only the order within the identifier of the output counts
task automatic model_release(input rsp_t got, input bit in_order);
  int exp_id;
  exp_id = in_order ? lowest_pending_id() : int'(got.id);
  if (exp_id < 0 || model_q[exp_id].size() == 0) begin
    report_failure($sformatf("output handshake for id %0d with nothing pending", got.id));
  end else begin
    compare_rsp("o_out_rsp", got, model_q[exp_id][0]);
    void'(model_q[exp_id].pop_front());
  end
  occupancy--;
endtask

`endif

// ==== tests/tb_simmem_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the write response bank. Runs reset, random traffic,
// a fill under back-pressure, a priority drain and an idle latency check
// against the reference model, then prints the error counts.
////////////////////////////////////////////////////////////////////////////

module tb_simmem_bank import simmem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RandomCycles = 600;
  localparam int WaitLimit = 100;

  logic clk_i;
  logic rst_ni;
  logic i_in_valid;
  rsp_t i_in_rsp;
  logic o_in_ready;
  logic o_out_valid;
  rsp_t o_out_rsp;
  logic i_out_ready;

  integer seed;
  // Drain phase checks the identifier priority too
  bit in_order;
  int accept_total;

  `include "tb_simmem_model.svh"

  simmem_bank dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_in_valid  (i_in_valid),
    .i_in_rsp    (i_in_rsp),
    .o_in_ready  (o_in_ready),
    .o_out_valid (o_out_valid),
    .o_out_rsp   (o_out_rsp),
    .i_out_ready (i_out_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] random_bits();
    logic [31:0] word;
    word = $random(seed);
    return word;
  endfunction

  function automatic rsp_t random_rsp();
    logic [31:0] word;
    word = random_bits();
    return word[$bits(rsp_t)-1:0];
  endfunction

  // One cycle of stimulus on the falling edge
  // Ready and valid are registered, so the next edge's handshakes are known here
  task automatic drive_cycle(input logic in_valid, input rsp_t in_rsp, input logic out_ready);
    @(negedge clk_i);
    compare_flag("o_in_ready", o_in_ready, occupancy < int'(BankCapacity));
    i_in_valid = in_valid;
    i_in_rsp = in_rsp;
    i_out_ready = out_ready;
    if (o_out_valid && out_ready) begin
      model_release(o_out_rsp, in_order);
    end
    if (in_valid && o_in_ready) begin
      model_push(in_rsp);
      accept_total++;
    end
  endtask

  task automatic wait_until_empty();
    int waited;
    waited = 0;
    while (occupancy != 0 && waited < WaitLimit) begin
      drive_cycle(1'b0, '0, 1'b1);
      waited++;
    end
    if (occupancy != 0) begin
      report_failure("timeout while waiting for the bank to drain");
    end
  endtask

  initial begin
    logic [31:0] word;
    rsp_t held;
    bit have_held;
    int waited;
    int low_cycles;
    int fill_start;

    seed = 32'h5675;
    rst_ni = 1'b0;
    i_in_valid = 1'b0;
    i_in_rsp = '0;
    i_out_ready = 1'b0;
    in_order = 1'b0;
    occupancy = 0;
    accept_total = 0;
    mismatch_count = 0;
    failure_count = 0;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset state
    compare_flag("o_out_valid", o_out_valid, 1'b0);
    compare_flag("o_in_ready", o_in_ready, 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // Random traffic in slow and fast output phases
    ////////////////////////////////////////////////////////////////////////////

    for (int cycle = 0; cycle < RandomCycles; cycle++) begin
      word = random_bits();
      if (((cycle / 100) % 2) == 0) begin
        drive_cycle(word[0], random_rsp(), word[3:2] == 2'b11);
      end else begin
        drive_cycle(word[0], random_rsp(), word[3:2] != 2'b00);
      end
    end
    wait_until_empty();

    ////////////////////////////////////////////////////////////////////////////
    // Fill under back-pressure
    ////////////////////////////////////////////////////////////////////////////

    have_held = 1'b0;
    fill_start = accept_total;
    waited = 0;
    low_cycles = 0;
    // Bank is empty, so the first push is the first to reach the output
    held = random_rsp();
    drive_cycle(1'b1, held, 1'b0);
    // Keep pushing a few cycles past full
    while (low_cycles < 4 && waited < WaitLimit) begin
      drive_cycle(1'b1, random_rsp(), 1'b0);
      if (have_held) begin
        compare_flag("o_out_valid", o_out_valid, 1'b1);
      end
      if (o_out_valid) begin
        have_held = 1'b1;
        compare_rsp("o_out_rsp", o_out_rsp, held);
      end
      if (!o_in_ready) begin
        low_cycles++;
      end
      waited++;
    end
    if (waited >= WaitLimit) begin
      report_failure("timeout while filling the bank");
    end
    if (accept_total - fill_start != int'(BankCapacity)) begin
      report_failure($sformatf("fill accepted %0d responses instead of %0d",
                               accept_total - fill_start, BankCapacity));
    end
    if (!have_held) begin
      report_failure("no response reached the output during the fill");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Drain in priority order
    ////////////////////////////////////////////////////////////////////////////

    // Held response leaves first
    drive_cycle(1'b0, '0, 1'b1);
    in_order = 1'b1;
    wait_until_empty();
    in_order = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Idle latency
    ////////////////////////////////////////////////////////////////////////////

    drive_cycle(1'b0, '0, 1'b1);
    compare_flag("o_out_valid", o_out_valid, 1'b0);
    // Accepted at the next rising edge
    drive_cycle(1'b1, random_rsp(), 1'b1);
    drive_cycle(1'b0, '0, 1'b1);
    compare_flag("o_out_valid", o_out_valid, 1'b0);
    drive_cycle(1'b0, '0, 1'b1);
    compare_flag("o_out_valid", o_out_valid, 1'b1);
    wait_until_empty();
    drive_cycle(1'b0, '0, 1'b0);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
